// File: hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Fetch packet layout, two 4-byte slots per 8-byte packet
    localparam int ADDR_W = 32;
    localparam int IDX_W  = 5;
    localparam int TAG_W  = 24;
    localparam int ROWS   = 1 << IDX_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic              slot_t;

    // Two speculative histories, slot 0 in bits 3..2
    typedef logic [3:0] guess_t;

    // Counter k sits at ctr[2k+1:2k]
    typedef struct packed {
        logic [1:0] hist;
        logic [7:0] ctr;
    } pattern_t;

    // Counter seeds for a fresh pattern entry
    localparam logic [1:0] CTR_INIT_TAKEN = 2'd2;
    localparam logic [1:0] CTR_INIT_NOT   = 2'd1;

    // Row index from pc bits 7..3
    function automatic logic [IDX_W-1:0] pc_idx(addr_t pc);
        return pc[IDX_W+2:3];
    endfunction

    // Tag from pc bits 31..8
    function automatic logic [TAG_W-1:0] pc_tag(addr_t pc);
        return pc[ADDR_W-1:ADDR_W-TAG_W];
    endfunction

    // Counter selected by a history value
    function automatic logic [1:0] ctr_of(pattern_t p, logic [1:0] h);
        return p.ctr[2*h +: 2];
    endfunction

endpackage

`default_nettype wire

// File: hdl/bp_ifs.sv
`default_nettype none

// Combinational lookup of both slots of one packet
interface bp_lookup_if #(
    parameter type T = logic
);
    bp_pkg::addr_t pc;

    // Per-slot hit and payload
    logic hit0;
    logic hit1;
    T     data0;
    T     data1;

    // Side that asks
    modport requester (
        output pc,
        input  hit0, hit1, data0, data1
    );

    // Side that answers
    modport tbl (
        input  pc,
        output hit0, hit1, data0, data1
    );
endinterface

// One-slot write, lands at the next rising edge
interface bp_write_if #(
    parameter type T = logic
);
    logic                     we;
    logic [bp_pkg::IDX_W-1:0] idx;
    logic [bp_pkg::TAG_W-1:0] tag;
    bp_pkg::slot_t            slot;
    T                         data;

    modport writer (output we, idx, tag, slot, data);
    modport tbl    (input  we, idx, tag, slot, data);
endinterface

`default_nettype wire

// File: hdl/bp_table.sv
`default_nettype none

module bp_table #(
    parameter type T = logic
) (
    input wire       clk,
    input wire       rstn,
    bp_lookup_if.tbl lookup [2],
    bp_write_if.tbl  write
);

    // One tag per row, shared by both slots
    logic [bp_pkg::TAG_W-1:0] tag_mem [bp_pkg::ROWS];
    // Payload per slot per row
    T                         data_mem [2][bp_pkg::ROWS];
    // valid[slot][row]
    logic [1:0][bp_pkg::ROWS-1:0] valid;

    logic new_tag;

    //////////////////////////////
    // Lookup ports
    //////////////////////////////

    // Two readers, both answered in the same cycle
    for (genvar g = 0; g < 2; g++) begin : g_lookup
        logic [bp_pkg::IDX_W-1:0] idx;
        logic                     tag_eq;

        assign idx    = bp_pkg::pc_idx(lookup[g].pc);
        assign tag_eq = tag_mem[idx] == bp_pkg::pc_tag(lookup[g].pc);

        // Hit needs valid slot and matching row tag
        assign lookup[g].hit0  = valid[0][idx] && tag_eq;
        assign lookup[g].hit1  = valid[1][idx] && tag_eq;
        assign lookup[g].data0 = data_mem[0][idx];
        assign lookup[g].data1 = data_mem[1][idx];
    end

    //////////////////////////////
    // Write port
    //////////////////////////////

    // Row taken over by another packet
    assign new_tag = write.tag != tag_mem[write.idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (write.we) begin
            valid[write.slot][write.idx] <= 1'b1;
            // Other slot belonged to the old tag
            if (new_tag) begin
                valid[~write.slot][write.idx] <= 1'b0;
            end
        end
    end

    // Tag and payload storage
    always_ff @(posedge clk) begin
        if (write.we) begin
            tag_mem[write.idx]              <= write.tag;
            data_mem[write.slot][write.idx] <= write.data;
        end
    end

    // Writer must always name a slot
    a_slot_known : assert property (
        @(posedge clk) disable iff (!rstn)
        write.we |-> !$isunknown(write.slot)
    ) else $error("bp_table: write slot unknown while we is high");

endmodule

`default_nettype wire

// File: hdl/guess_ram.sv
`default_nettype none

module guess_ram (
    input  wire                           clk,
    input  wire                           we,
    input  wire [bp_pkg::IDX_W-1:0]       addr,
    input  wire bp_pkg::guess_t           wdata,
    output bp_pkg::guess_t                rdata
);

    // Speculative history per packet row
    bp_pkg::guess_t mem [bp_pkg::ROWS];

    // Read is combinational, same row as the write
    assign rdata = mem[addr];

    // Written on every fetch
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/predict_unit.sv
`default_nettype none

module predict_unit (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 fetch_en,
    input  wire bp_pkg::addr_t  pc_now,
    bp_lookup_if.requester      btb,
    bp_lookup_if.requester      pht,
    input  wire                 resolve_vld,
    input  wire                 resolve_wrong,
    output bp_pkg::addr_t       pc_new,
    output logic                branch,
    output bp_pkg::slot_t       slot,
    output logic                known
);

    logic [bp_pkg::IDX_W-1:0] idx;
    bp_pkg::guess_t           g_rd;
    bp_pkg::guess_t           g_wr;

    // One guess flag per row and slot
    logic [bp_pkg::ROWS-1:0]  flag0;
    logic [bp_pkg::ROWS-1:0]  flag1;

    bp_pkg::addr_t            tgt0, tgt1;
    bp_pkg::pattern_t         p0, p1;
    logic [1:0]               h0, h1;
    logic [1:0]               c0, c1;
    logic                     cnt0, cnt1;
    logic                     back0, back1;
    logic                     tk0, tk1;
    logic                     use0, use1;

    // Both tables looked up with the fetch pc
    assign btb.pc = pc_now;
    assign pht.pc = pc_now;
    assign idx    = bp_pkg::pc_idx(pc_now);

    assign tgt0 = btb.data0;
    assign tgt1 = btb.data1;
    assign p0   = pht.data0;
    assign p1   = pht.data1;

    //////////////////////////////
    // Guess log
    //////////////////////////////

    guess_ram u_guess (
        .clk   (clk),
        .we    (fetch_en),
        .addr  (idx),
        .wdata (g_wr),
        .rdata (g_rd)
    );

    // Speculative history wins while the flag is up
    assign h0 = flag0[idx] ? g_rd[3:2] : p0.hist;
    assign h1 = flag1[idx] ? g_rd[1:0] : p1.hist;

    // Pattern-table use this fetch
    assign use0 = cnt0 && pht.hit0;
    assign use1 = cnt1 && pht.hit1 && !tk0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            flag0 <= '0;
            flag1 <= '0;
        end else if (fetch_en && resolve_vld) begin
            if (resolve_wrong) begin
                // Misprediction, back to committed history
                flag0 <= '0;
                flag1 <= '0;
            end else begin
                // Stays set until a wrong resolve
                flag0[idx] <= flag0[idx] | use0;
                flag1[idx] <= flag1[idx] | use1;
            end
        end
    end

    // Old low history bit, then this guess
    assign g_wr = {h0[0], tk0, h1[0], tk1};

    //////////////////////////////
    // Slot prediction
    //////////////////////////////

    // Slot 0 skipped when fetch enters mid-packet
    assign cnt0 = btb.hit0 && !pc_now[2];
    assign cnt1 = btb.hit1;

    // Backward branch fallback
    assign back0 = tgt0[bp_pkg::ADDR_W-1:2] < pc_now[bp_pkg::ADDR_W-1:2];
    assign back1 = tgt1[bp_pkg::ADDR_W-1:2] < pc_now[bp_pkg::ADDR_W-1:2];

    assign c0 = bp_pkg::ctr_of(p0, h0);
    assign c1 = bp_pkg::ctr_of(p1, h1);

    // Counter MSB with a pattern hit, direction otherwise
    assign tk0 = cnt0 && (pht.hit0 ? c0[1] : back0);
    assign tk1 = cnt1 && (pht.hit1 ? c1[1] : back1);

    assign branch = tk0 | tk1;
    assign slot   = tk1 & ~tk0;
    assign known  = cnt0 | cnt1;

    // Taken target or next packet
    assign pc_new = branch ?
        {(tk0 ? tgt0[bp_pkg::ADDR_W-1:2] : tgt1[bp_pkg::ADDR_W-1:2]), 2'b00} :
        {pc_now[bp_pkg::ADDR_W-1:3] + 1'b1, 3'b000};

    a_branch_known : assert property (
        @(posedge clk) disable iff (!rstn)
        branch |-> known
    ) else $error("predict_unit: branch without known");

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rstn)
        pc_new[1:0] == 2'b00
    ) else $error("predict_unit: pc_new not word aligned");

endmodule

`default_nettype wire

// File: hdl/history_update.sv
`default_nettype none

module history_update (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 resolve_vld,
    input  wire bp_pkg::addr_t  resolve_pc,
    input  wire bp_pkg::slot_t  resolve_slot,
    input  wire                 resolve_taken,
    input  wire bp_pkg::addr_t  resolve_target,
    bp_lookup_if.requester      btb_q,
    bp_lookup_if.requester      pht_q,
    bp_write_if.writer          btb_w,
    bp_write_if.writer          pht_w
);

    logic             btb_slot_hit;
    logic             pht_slot_hit;
    bp_pkg::pattern_t pht_slot_data;

    // Captured resolve
    logic             r_vld;
    bp_pkg::addr_t    r_pc;
    bp_pkg::addr_t    r_target;
    bp_pkg::slot_t    r_slot;
    logic             r_taken;
    logic             r_btb_hit;
    logic             r_pht_hit;
    bp_pkg::pattern_t r_pht;

    logic [1:0]       old_h, old_c, new_c, init_c;
    bp_pkg::pattern_t upd, fresh;

    // Look up the resolving packet
    assign btb_q.pc = resolve_pc;
    assign pht_q.pc = resolve_pc;

    assign btb_slot_hit  = resolve_slot ? btb_q.hit1 : btb_q.hit0;
    assign pht_slot_hit  = resolve_slot ? pht_q.hit1 : pht_q.hit0;
    assign pht_slot_data = resolve_slot ? pht_q.data1 : pht_q.data0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_vld <= 1'b0;
        end else begin
            r_vld <= resolve_vld;
        end
    end

    // Overwritten every cycle
    always_ff @(posedge clk) begin
        r_pc      <= resolve_pc;
        r_target  <= resolve_target;
        r_slot    <= resolve_slot;
        r_taken   <= resolve_taken;
        r_btb_hit <= btb_slot_hit;
        r_pht_hit <= pht_slot_hit;
        r_pht     <= pht_slot_data;
    end

    //////////////////////////////
    // Counter update
    //////////////////////////////

    assign old_h = r_pht.hist;
    assign old_c = bp_pkg::ctr_of(r_pht, old_h);

    // Saturating step
    always_comb begin
        if (r_taken) begin
            new_c = (old_c == 2'd3) ? old_c : old_c + 2'd1;
        end else begin
            new_c = (old_c == 2'd0) ? old_c : old_c - 2'd1;
        end
    end

    // Existing entry, history shifts in the outcome
    always_comb begin
        upd = r_pht;
        upd.ctr[2*old_h +: 2] = new_c;
        upd.hist = {old_h[0], r_taken};
    end

    // New entry seeded by the outcome
    assign init_c     = r_taken ? bp_pkg::CTR_INIT_TAKEN : bp_pkg::CTR_INIT_NOT;
    assign fresh.ctr  = {4{init_c}};
    assign fresh.hist = {1'b0, r_taken};

    //////////////////////////////
    // Table writes
    //////////////////////////////

    // Target only learned on taken
    assign btb_w.we   = r_vld && r_taken;
    assign btb_w.idx  = bp_pkg::pc_idx(r_pc);
    assign btb_w.tag  = bp_pkg::pc_tag(r_pc);
    assign btb_w.slot = r_slot;
    assign btb_w.data = r_target;

    // Pattern needs a known branch first
    assign pht_w.we   = r_vld && r_btb_hit;
    assign pht_w.idx  = bp_pkg::pc_idx(r_pc);
    assign pht_w.tag  = bp_pkg::pc_tag(r_pc);
    assign pht_w.slot = r_slot;
    assign pht_w.data = r_pht_hit ? upd : fresh;

    a_pht_after_btb : assert property (
        @(posedge clk) disable iff (!rstn)
        pht_w.we |-> $past(resolve_vld && btb_slot_hit)
    ) else $error("history_update: pattern write without target hit");

endmodule

`default_nettype wire

// File: hdl/branch_predictor_top.sv
`default_nettype none

module branch_predictor_top (
    input  wire                 clk,
    input  wire                 rstn,

    // Fetch side
    input  wire                 fetch_en,
    input  wire bp_pkg::addr_t  pc_now,
    output bp_pkg::addr_t       pc_new,
    output logic                branch,
    output bp_pkg::slot_t       slot,
    output logic                known,

    // Resolve from execute
    input  wire                 resolve_vld,
    input  wire bp_pkg::addr_t  resolve_pc,
    input  wire bp_pkg::slot_t  resolve_slot,
    input  wire                 resolve_taken,
    input  wire bp_pkg::addr_t  resolve_target,
    input  wire                 resolve_wrong
);

    // Index 0 for fetch, 1 for the updater
    bp_lookup_if #(.T(bp_pkg::addr_t))    btb_lk [2] ();
    bp_lookup_if #(.T(bp_pkg::pattern_t)) pht_lk [2] ();

    bp_write_if #(.T(bp_pkg::addr_t))    btb_wr ();
    bp_write_if #(.T(bp_pkg::pattern_t)) pht_wr ();

    // Target buffer
    bp_table #(.T(bp_pkg::addr_t)) btb_tbl (
        .clk    (clk),
        .rstn   (rstn),
        .lookup (btb_lk),
        .write  (btb_wr)
    );

    // Pattern table
    bp_table #(.T(bp_pkg::pattern_t)) pht_tbl (
        .clk    (clk),
        .rstn   (rstn),
        .lookup (pht_lk),
        .write  (pht_wr)
    );

    history_update u_update (
        .clk            (clk),
        .rstn           (rstn),
        .resolve_vld    (resolve_vld),
        .resolve_pc     (resolve_pc),
        .resolve_slot   (resolve_slot),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .btb_q          (btb_lk[1]),
        .pht_q          (pht_lk[1]),
        .btb_w          (btb_wr),
        .pht_w          (pht_wr)
    );

    predict_unit u_predict (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_en      (fetch_en),
        .pc_now        (pc_now),
        .btb           (btb_lk[0]),
        .pht           (pht_lk[0]),
        .resolve_vld   (resolve_vld),
        .resolve_wrong (resolve_wrong),
        .pc_new        (pc_new),
        .branch        (branch),
        .slot          (slot),
        .known         (known)
    );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    // Period 40
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over three rising edges
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/bp_tb.sv
`default_nettype none

module bp_tb;

    // Cycle budgets, reset then tests 1 to 5
    localparam int BUDGET   = 4 + 24 + 16 + 32 + 24 + 40;
    localparam int WATCHDOG = BUDGET * 40 * 3 / 2;

    logic          clk;
    logic          rstn;
    logic          fetch_en;
    bp_pkg::addr_t pc_now;
    bp_pkg::addr_t pc_new;
    logic          branch;
    bp_pkg::slot_t slot;
    logic          known;
    logic          resolve_vld;
    bp_pkg::addr_t resolve_pc;
    bp_pkg::slot_t resolve_slot;
    logic          resolve_taken;
    bp_pkg::addr_t resolve_target;
    logic          resolve_wrong;

    // Model tables, 0 is the target buffer, 1 the pattern table
    logic [23:0]   m_tag [2][32];
    logic          m_val [2][2][32];
    logic [31:0]   m_dat [2][2][32];
    logic          m_flag [2][32];
    logic [3:0]    m_guess [32];

    // Resolve waiting for its write edge
    logic          q_vld, q_taken, q_bhit, q_phit;
    bp_pkg::slot_t q_slot;
    bp_pkg::addr_t q_pc, q_tgt;
    logic [9:0]    q_pat;

    // Expected answer for the pc_now on the bus
    bp_pkg::addr_t exp_pc_new;
    logic          exp_branch, exp_slot, exp_known;
    logic          m_use0, m_use1;
    logic [3:0]    m_gwr;

    logic          chk_en;
    int            err_count;
    int            pass_tests;
    int            fail_tests;
    int            test_err0;
    int            seen_taken;

    tb_clk_gen u_clk (.clk(clk), .rstn(rstn));

    branch_predictor_top dut (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_en       (fetch_en),
        .pc_now         (pc_now),
        .pc_new         (pc_new),
        .branch         (branch),
        .slot           (slot),
        .known          (known),
        .resolve_vld    (resolve_vld),
        .resolve_pc     (resolve_pc),
        .resolve_slot   (resolve_slot),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .resolve_wrong  (resolve_wrong)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Row from pc bits 7..3, tag from 31..8
    function automatic logic lk_hit(int t, bp_pkg::addr_t pc, int s);
        return m_val[t][s][pc[7:3]] && m_tag[t][pc[7:3]] == pc[31:8];
    endfunction

    task automatic tbl_write(int t, bp_pkg::addr_t pc, int s, logic [31:0] d);
        logic [4:0] i;
        i = pc[7:3];
        // New owner of the row drops the other slot
        if (m_tag[t][i] != pc[31:8]) m_val[t][1-s][i] = 1'b0;
        m_val[t][s][i] = 1'b1;
        m_tag[t][i]    = pc[31:8];
        m_dat[t][s][i] = d;
    endtask

    // Counter step and history shift, or a fresh entry
    function automatic logic [9:0] next_pat(logic [9:0] p, logic hit, logic tk);
        logic [1:0] h;
        logic [1:0] c;
        logic [9:0] r;
        if (!hit) return {1'b0, tk, {4{tk ? bp_pkg::CTR_INIT_TAKEN : bp_pkg::CTR_INIT_NOT}}};
        h = p[9:8];
        c = p[2*h +: 2];
        if (tk && c != 2'd3) c = c + 2'd1;
        else if (!tk && c != 2'd0) c = c - 2'd1;
        r = p;
        r[2*h +: 2] = c;
        r[9:8] = {h[0], tk};
        return r;
    endfunction

    task automatic predict_model();
        logic [4:0]    i;
        logic [9:0]    p0, p1;
        logic [1:0]    h0, h1;
        logic          b0, b1, ph0, ph1, t0, t1;
        bp_pkg::addr_t g0, g1;
        i   = pc_now[7:3];
        b0  = lk_hit(0, pc_now, 0) && !pc_now[2];
        b1  = lk_hit(0, pc_now, 1);
        ph0 = lk_hit(1, pc_now, 0);
        ph1 = lk_hit(1, pc_now, 1);
        p0  = m_dat[1][0][i][9:0];
        p1  = m_dat[1][1][i][9:0];
        g0  = m_dat[0][0][i];
        g1  = m_dat[0][1][i];
        // Speculative history while flagged
        h0  = m_flag[0][i] ? m_guess[i][3:2] : p0[9:8];
        h1  = m_flag[1][i] ? m_guess[i][1:0] : p1[9:8];
        t0  = b0 && (ph0 ? p0[2*h0+1] : g0 < pc_now);
        t1  = b1 && (ph1 ? p1[2*h1+1] : g1 < pc_now);
        exp_known  = b0 | b1;
        exp_branch = t0 | t1;
        exp_slot   = !t0 && t1;
        if (t0) exp_pc_new = {g0[31:2], 2'b00};
        else if (t1) exp_pc_new = {g1[31:2], 2'b00};
        else exp_pc_new = {pc_now[31:3] + 29'd1, 3'b000};
        m_use0 = b0 && ph0;
        m_use1 = b1 && ph1 && !t0;
        m_gwr  = {h0[0], t0, h1[0], t1};
    endtask

    task automatic clear_flags();
        foreach (m_flag[s, r]) m_flag[s][r] = 1'b0;
    endtask

    always @(posedge clk or negedge rstn) begin
        logic       nb;
        logic       np;
        logic [9:0] nd;
        if (!rstn) begin
            foreach (m_val[t, s, r]) m_val[t][s][r] = 1'b0;
            clear_flags();
            q_vld = 1'b0;
        end else begin
            // Lookup seen by the resolve sampled now, before the pending write
            nb = lk_hit(0, resolve_pc, resolve_slot);
            np = lk_hit(1, resolve_pc, resolve_slot);
            nd = m_dat[1][resolve_slot][resolve_pc[7:3]][9:0];
            if (q_vld && q_taken) tbl_write(0, q_pc, q_slot, q_tgt);
            if (q_vld && q_bhit) tbl_write(1, q_pc, q_slot, {22'd0, next_pat(q_pat, q_phit, q_taken)});
            q_vld   = resolve_vld;
            q_pc    = resolve_pc;
            q_slot  = resolve_slot;
            q_taken = resolve_taken;
            q_tgt   = resolve_target;
            q_bhit  = nb;
            q_phit  = np;
            q_pat   = nd;
            // Guess log and flags move on fetch edges only
            if (fetch_en) begin
                m_guess[pc_now[7:3]] = m_gwr;
                if (resolve_vld && resolve_wrong) begin
                    clear_flags();
                end else if (resolve_vld) begin
                    m_flag[0][pc_now[7:3]] = m_flag[0][pc_now[7:3]] | m_use0;
                    m_flag[1][pc_now[7:3]] = m_flag[1][pc_now[7:3]] | m_use1;
                end
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_pc_new : assert property (@(posedge clk) disable iff (!rstn) chk_en |-> pc_new == exp_pc_new)
        else begin
            err_count++;
            $display("** Error pc_new: got %h expected %h", $sampled(pc_new), $sampled(exp_pc_new));
        end
    a_branch : assert property (@(posedge clk) disable iff (!rstn) chk_en |-> branch == exp_branch)
        else begin
            err_count++;
            $display("** Error branch: got %h expected %h", $sampled(branch), $sampled(exp_branch));
        end
    a_slot : assert property (@(posedge clk) disable iff (!rstn) chk_en |-> !branch || slot == exp_slot)
        else begin
            err_count++;
            $display("** Error slot: got %h expected %h", $sampled(slot), $sampled(exp_slot));
        end
    a_known : assert property (@(posedge clk) disable iff (!rstn) chk_en |-> known == exp_known)
        else begin
            err_count++;
            $display("** Error known: got %h expected %h", $sampled(known), $sampled(exp_known));
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One cycle of inputs, 5 units after the edge
    task automatic step(bp_pkg::addr_t pc, logic fe, logic rv, bp_pkg::addr_t rpc,
                        logic rs, logic rt, bp_pkg::addr_t rtg, logic rw);
        @(posedge clk);
        #5;
        fetch_en       = fe;
        pc_now         = pc;
        resolve_vld    = rv;
        resolve_pc     = rpc;
        resolve_slot   = rs;
        resolve_taken  = rt;
        resolve_target = rtg;
        resolve_wrong  = rw;
        predict_model();
        chk_en = 1'b1;
        if (exp_branch) seen_taken++;
    endtask

    task automatic fetch(bp_pkg::addr_t pc);
        step(pc, 1'b1, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic resolve(bp_pkg::addr_t pc, bp_pkg::addr_t rpc, logic rs, logic rt,
                           bp_pkg::addr_t rtg, logic rw);
        step(pc, 1'b1, 1'b1, rpc, rs, rt, rtg, rw);
    endtask

    // Random tag, fixed row, room for targets on both sides
    function automatic bp_pkg::addr_t rand_packet(int row);
        logic [31:0] r;
        r = $urandom;
        return {2'b01, r[29:8], row[4:0], 3'b000};
    endfunction

    task automatic end_test(string name, logic need_taken);
        @(posedge clk);
        #1;
        if (err_count != test_err0) begin
            fail_tests++;
            $display("Test %-12s FAIL with %0d mismatches", name, err_count - test_err0);
        end else if (need_taken && seen_taken == 0) begin
            fail_tests++;
            $display("Test %-12s FAIL, stimulus never reached a taken prediction", name);
        end else begin
            pass_tests++;
            $display("Test %-12s PASS", name);
        end
        test_err0  = err_count;
        seen_taken = 0;
    endtask

    initial begin
        logic [31:0]   r;
        bp_pkg::addr_t z, z2, a, b, c, f, d;
        logic [8:0]    walk;
        logic [5:0]    train;
        fetch_en = 1'b0;
        pc_now = '0;
        resolve_vld = 1'b0;
        resolve_pc = '0;
        resolve_slot = 1'b0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_wrong = 1'b0;
        chk_en = 1'b0;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        test_err0 = 0;
        seen_taken = 0;
        void'($urandom(98545));
        // Rows with no entries, used as idle fetch and idle resolve
        z  = rand_packet(20);
        z2 = rand_packet(25);
        wait (rstn);

        // Empty tables fall through to the next packet
        for (int k = 0; k < 20; k++) begin
            r = $urandom;
            fetch({r[31:2], 2'b00});
        end
        end_test("reset", 1'b0);

        // Direction fallback, backward at a and forward in slot 1 of b
        a = rand_packet(3);
        b = rand_packet(6);
        resolve(z, a, 1'b0, 1'b1, a - 32'h100, 1'b0);
        resolve(z, b + 32'd4, 1'b1, 1'b1, b + 32'h200, 1'b0);
        fetch(z);
        fetch(a);
        fetch(a + 32'd4);
        fetch(b);
        fetch(b + 32'd4);
        end_test("btb_only", 1'b1);

        // Create, saturate low, then climb back
        walk = 9'b1_000000_11;
        for (int k = 8; k >= 0; k--) begin
            resolve(z, a, 1'b0, walk[k], a - 32'h100, 1'b0);
            fetch(a);
            fetch(a);
        end
        end_test("pattern", 1'b1);

        // Slot 1 first, then slot 0 wins, then mid-packet entry
        c = rand_packet(9);
        f = rand_packet(12);
        resolve(z, c, 1'b0, 1'b1, c + 32'h300, 1'b0);
        resolve(z, c + 32'd4, 1'b1, 1'b1, c - 32'h80, 1'b0);
        resolve(z, f, 1'b0, 1'b1, f - 32'h40, 1'b0);
        fetch(z);
        fetch(c);
        resolve(z, c, 1'b0, 1'b1, c - 32'h40, 1'b0);
        fetch(z);
        fetch(c);
        fetch(c + 32'd4);
        fetch(f + 32'd4);
        fetch(f);
        end_test("slots", 1'b1);

        // Uneven counters so the guess history changes the answer
        d = rand_packet(14);
        train = 6'b110001;
        for (int k = 5; k >= 0; k--) begin
            resolve(z, d, 1'b0, train[k], d - 32'h20, 1'b0);
        end
        fetch(z);
        fetch(z);
        repeat (5) resolve(d, z2, 1'b0, 1'b0, z2, 1'b0);
        // No fetch, guess log holds
        step(d, 1'b0, 1'b1, z2, 1'b0, 1'b0, z2, 1'b0);
        fetch(d);
        fetch(d);
        // Mispredict drops every flag
        resolve(d, z2, 1'b0, 1'b0, z2, 1'b1);
        fetch(d);
        fetch(d);
        end_test("speculation", 1'b1);

        $display("Tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG);
        $display("Watchdog expired, run did not finish within %0d time units", WATCHDOG);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/bp_pkg.sv
hdl/bp_ifs.sv
hdl/bp_table.sv
hdl/guess_ram.sv
hdl/predict_unit.sv
hdl/history_update.sv
hdl/branch_predictor_top.sv
verif/tb_clk_gen.sv
verif/bp_tb.sv

// File: Makefile
TOP = bp_tb

.PHONY: all build lint clean

# Build, run, then look for the pass line in the output
all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

lint:
	verilator --lint-only --timing -Wall --top-module branch_predictor_top -f src.f

clean:
	rm -rf obj_dir
